// File: nes_input_params.svh
`ifndef NES_INPUT_PARAMS_SVH
`define NES_INPUT_PARAMS_SVH

// serial report shifted out per controller port
`define NES_REPORT_BITS 24

// multitap signature bytes, sent as the third byte of each report
`define NES_SIG_PORT1 8'h08
`define NES_SIG_PORT2 8'h04

// sent in place of absent pads and signatures
`define NES_FILL_BYTE 8'hFF

// core stays in reset this many unpaused cycles after a download ends
`define NES_DL_RESET_CYCLES 255
`define NES_DL_CNT_BITS 8

`endif

// File: nes_input_pkg.sv
`default_nettype none

package nes_input_pkg;

  // one controller, in NES read order from bit 0 (a) to bit 7 (right)
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_buttons_t;

  // one port's serial report, bit 0 goes out first
  typedef logic [23:0] pad_report_t;

  // post-download countdown
  typedef logic [7:0] dl_count_t;

  // console port clocks, bit 0 is port 1
  typedef logic [1:0] port_strobe_t;

endpackage

`default_nettype wire

// File: pad_report_builder.sv
`default_nettype none

`include "nes_input_params.svh"

module pad_report_builder (
  input  wire                          clk_ppu_21_47,
  input  wire                          reset_nes,
  input  wire nes_input_pkg::pad_buttons_t pad1,
  input  wire nes_input_pkg::pad_buttons_t pad2,
  input  wire nes_input_pkg::pad_buttons_t pad3,
  input  wire nes_input_pkg::pad_buttons_t pad4,
  input  wire                          multitap_enabled,
  output nes_input_pkg::pad_report_t   report_p1,
  output nes_input_pkg::pad_report_t   report_p2
);

  nes_input_pkg::pad_report_t next_p1;
  nes_input_pkg::pad_report_t next_p2;

  // own pad in the low byte, then either the multitap pad and
  // signature or two fill bytes
  function automatic nes_input_pkg::pad_report_t build_report(
    input nes_input_pkg::pad_buttons_t main_pad,
    input nes_input_pkg::pad_buttons_t tap_pad,
    input logic [7:0]                  signature,
    input logic                        tap_on
  );
    nes_input_pkg::pad_report_t rep;
    if (tap_on) begin
      rep = {signature, tap_pad, main_pad};
    end else begin
      rep = {`NES_FILL_BYTE, `NES_FILL_BYTE, main_pad};
    end
    return rep;
  endfunction

  always_comb begin
    next_p1 = build_report(pad1, pad3, `NES_SIG_PORT1, multitap_enabled);
    next_p2 = build_report(pad2, pad4, `NES_SIG_PORT2, multitap_enabled);
  end

  // registered copy, one cycle behind the pads
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      report_p1 <= {`NES_REPORT_BITS{1'b1}};
      report_p2 <= {`NES_REPORT_BITS{1'b1}};
    end else begin
      report_p1 <= next_p1;
      report_p2 <= next_p2;
    end
  end

endmodule

`default_nettype wire

// File: pad_shift_port.sv
`default_nettype none

module pad_shift_port (
  input  wire                             clk_ppu_21_47,
  input  wire                             reset_nes,
  input  wire nes_input_pkg::pad_report_t report,
  input  wire                             strobe,
  input  wire                             port_clock,
  output logic                            data
);

  localparam int unsigned ReportBits = $bits(nes_input_pkg::pad_report_t);

  nes_input_pkg::pad_report_t shift_q;
  logic                       port_clock_q;
  logic                       clock_fall;

  // falling edge seen against last cycle's clock level
  assign clock_fall = port_clock_q & ~port_clock;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      shift_q      <= '0;
      port_clock_q <= 1'b0;
    end else begin
      port_clock_q <= port_clock;
      // shift takes priority over a load in the same cycle
      if (clock_fall) begin
        shift_q <= {1'b0, shift_q[ReportBits-1:1]};
      end else if (strobe) begin
        shift_q <= report;
      end
    end
  end

  assign data = shift_q[0];

  // console reads this pin directly
  a_data_known: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    !$isunknown(data)
  );

endmodule

`default_nettype wire

// File: core_reset_seq.sv
`default_nettype none

`include "nes_input_params.svh"

module core_reset_seq (
  input  wire  clk_ppu_21_47,
  input  wire  reset_nes,
  input  wire  download,
  input  wire  loader_busy,
  input  wire  loader_fail,
  input  wire  external_reset,
  output logic core_reset,
  output logic loader_reset
);

  typedef enum logic [1:0] {
    ST_WAIT_FIRST,
    ST_DOWNLOADING,
    ST_COUNTING,
    ST_RUNNING
  } seq_state_t;

  seq_state_t                state_q;
  seq_state_t                state_d;
  nes_input_pkg::dl_count_t  cnt_q;
  nes_input_pkg::dl_count_t  cnt_d;
  logic                      download_q;
  logic                      download_rise;

  assign download_rise = download & ~download_q;

  // countdown pauses while the loader is still busy
  always_comb begin
    cnt_d = cnt_q;
    if (download) begin
      cnt_d = nes_input_pkg::dl_count_t'(`NES_DL_RESET_CYCLES);
    end else if (!loader_busy && cnt_q != '0) begin
      cnt_d = cnt_q - nes_input_pkg::dl_count_t'(1);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_WAIT_FIRST:  if (download) state_d = ST_DOWNLOADING;
      ST_DOWNLOADING: if (!download) state_d = ST_COUNTING;
      ST_COUNTING: begin
        if (download) begin
          state_d = ST_DOWNLOADING;
        end else if (cnt_d == '0) begin
          state_d = ST_RUNNING;
        end
      end
      ST_RUNNING:     if (download) state_d = ST_DOWNLOADING;
      default:        state_d = ST_WAIT_FIRST;
    endcase
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state_q      <= ST_WAIT_FIRST;
      cnt_q        <= '0;
      download_q   <= 1'b0;
      loader_reset <= 1'b1;
    end else begin
      state_q      <= state_d;
      cnt_q        <= cnt_d;
      download_q   <= download;
      // loader restarts on each new download and idles in reset otherwise
      loader_reset <= (cnt_q == '0) | download_rise;
    end
  end

  // failures and the external request act in the same cycle
  assign core_reset = (cnt_q != '0) | (state_q == ST_WAIT_FIRST) |
                      loader_fail | external_reset;

  a_count_holds_reset: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    (cnt_q != '0) |-> core_reset
  );

  a_download_holds_reset: assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
    download |=> core_reset
  );

endmodule

`default_nettype wire

// File: nes_input_top.sv
`default_nettype none

module nes_input_top (
  input  wire                               clk_ppu_21_47,
  input  wire                               reset_nes,
  input  wire nes_input_pkg::pad_buttons_t  pad1,
  input  wire nes_input_pkg::pad_buttons_t  pad2,
  input  wire nes_input_pkg::pad_buttons_t  pad3,
  input  wire nes_input_pkg::pad_buttons_t  pad4,
  input  wire                               multitap_enabled,
  input  wire                               strobe,
  input  wire nes_input_pkg::port_strobe_t  port_clock,
  output logic                              data_p1,
  output logic                              data_p2,
  input  wire                               download,
  input  wire                               loader_busy,
  input  wire                               loader_fail,
  input  wire                               external_reset,
  output logic                              core_reset,
  output logic                              loader_reset
);

  nes_input_pkg::pad_report_t report_p1;
  nes_input_pkg::pad_report_t report_p2;

  // stage 1, one report per port
  pad_report_builder u_report (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .pad1             (pad1),
    .pad2             (pad2),
    .pad3             (pad3),
    .pad4             (pad4),
    .multitap_enabled (multitap_enabled),
    .report_p1        (report_p1),
    .report_p2        (report_p2)
  );

  // stage 2, strobe is shared, each port has its own clock
  pad_shift_port u_port1 (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .report        (report_p1),
    .strobe        (strobe),
    .port_clock    (port_clock[0]),
    .data          (data_p1)
  );

  pad_shift_port u_port2 (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .report        (report_p2),
    .strobe        (strobe),
    .port_clock    (port_clock[1]),
    .data          (data_p2)
  );

  core_reset_seq u_reset (
    .clk_ppu_21_47  (clk_ppu_21_47),
    .reset_nes      (reset_nes),
    .download       (download),
    .loader_busy    (loader_busy),
    .loader_fail    (loader_fail),
    .external_reset (external_reset),
    .core_reset     (core_reset),
    .loader_reset   (loader_reset)
  );

endmodule

`default_nettype wire

// File: tb_nes_input.sv
`default_nettype none

`include "nes_input_params.svh"

module tb_nes_input;

  timeunit 1ns;
  timeprecision 1ps;

  // the tests take roughly 6000 cycles, so this leaves ample margin
  localparam int MaxCycles = 20000;
  localparam int Seed = 72747;

  logic                        clk_ppu_21_47 = 1'b0;
  logic                        reset_nes;
  nes_input_pkg::pad_buttons_t pad1;
  nes_input_pkg::pad_buttons_t pad2;
  nes_input_pkg::pad_buttons_t pad3;
  nes_input_pkg::pad_buttons_t pad4;
  logic                        multitap_enabled;
  logic                        strobe;
  nes_input_pkg::port_strobe_t port_clock;
  logic                        data_p1;
  logic                        data_p2;
  logic                        download;
  logic                        loader_busy;
  logic                        loader_fail;
  logic                        external_reset;
  logic                        core_reset;
  logic                        loader_reset;

  int cycle_count = 0;
  int checks_failed = 0;
  int tests_run = 0;
  int tests_failed = 0;

  always #5 clk_ppu_21_47 = ~clk_ppu_21_47;

  nes_input_top i_nes_input_top (
    .clk_ppu_21_47    (clk_ppu_21_47),
    .reset_nes        (reset_nes),
    .pad1             (pad1),
    .pad2             (pad2),
    .pad3             (pad3),
    .pad4             (pad4),
    .multitap_enabled (multitap_enabled),
    .strobe           (strobe),
    .port_clock       (port_clock),
    .data_p1          (data_p1),
    .data_p2          (data_p2),
    .download         (download),
    .loader_busy      (loader_busy),
    .loader_fail      (loader_fail),
    .external_reset   (external_reset),
    .core_reset       (core_reset),
    .loader_reset     (loader_reset)
  );

  always @(posedge clk_ppu_21_47) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("timeout, the run did not finish within %0d cycles", MaxCycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // expected serial report of one port, bit 0 goes out first
  function automatic logic [23:0] expected_report(
    input nes_input_pkg::pad_buttons_t p1,
    input nes_input_pkg::pad_buttons_t p2,
    input nes_input_pkg::pad_buttons_t p3,
    input nes_input_pkg::pad_buttons_t p4,
    input logic                        tap,
    input int                          port
  );
    logic [7:0] own_byte;
    logic [7:0] tap_byte;
    logic [7:0] sig_byte;
    own_byte = (port == 1) ? p1 : p2;
    if (tap) begin
      tap_byte = (port == 1) ? p3 : p4;
      sig_byte = (port == 1) ? `NES_SIG_PORT1 : `NES_SIG_PORT2;
    end else begin
      tap_byte = `NES_FILL_BYTE;
      sig_byte = `NES_FILL_BYTE;
    end
    return {sig_byte, tap_byte, own_byte};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      checks_failed++;
    end
  endtask

  task automatic finish_test(input string name, input int fails_before);
    tests_run++;
    if (checks_failed > fails_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, checks_failed - fails_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // random pads, then two cycles so the report register settles
  task automatic apply_pads(input logic tap);
    logic [7:0] r1;
    logic [7:0] r2;
    logic [7:0] r3;
    logic [7:0] r4;
    r1 = 8'($urandom());
    r2 = 8'($urandom());
    r3 = 8'($urandom());
    r4 = 8'($urandom());
    pad1 <= r1;
    pad2 <= r2;
    pad3 <= r3;
    pad4 <= r4;
    multitap_enabled <= tap;
    repeat (2) @(posedge clk_ppu_21_47);
  endtask

  task automatic load_reports();
    strobe <= 1'b1;
    repeat (2) @(posedge clk_ppu_21_47);
    strobe <= 1'b0;
  endtask

  // sample before each falling port clock, every level held two cycles
  task automatic shift_bits(input nes_input_pkg::port_strobe_t mask,
                            output logic [31:0] got1, output logic [31:0] got2);
    int i;
    for (i = 0; i < 32; i++) begin
      @(negedge clk_ppu_21_47);
      got1[i] = data_p1;
      got2[i] = data_p2;
      @(posedge clk_ppu_21_47);
      port_clock <= mask;
      repeat (2) @(posedge clk_ppu_21_47);
      port_clock <= '0;
      @(posedge clk_ppu_21_47);
    end
  endtask

  task automatic pad_read_test(input string test_name, input logic tap, input int sets);
    logic [31:0] got1;
    logic [31:0] got2;
    logic [23:0] exp1;
    logic [23:0] exp2;
    int          fails_before;
    int          n;
    fails_before = checks_failed;
    for (n = 0; n < sets; n++) begin
      apply_pads(tap);
      exp1 = expected_report(pad1, pad2, pad3, pad4, tap, 1);
      exp2 = expected_report(pad1, pad2, pad3, pad4, tap, 2);
      load_reports();
      shift_bits(2'b11, got1, got2);
      check_value($sformatf("%s_%0d_p1", test_name, n), {8'h00, exp1}, got1);
      check_value($sformatf("%s_%0d_p2", test_name, n), {8'h00, exp2}, got2);
    end
    finish_test(test_name, fails_before);
  endtask

  task automatic single_port_test();
    logic [31:0] got1;
    logic [31:0] got2;
    logic [23:0] exp1;
    logic [23:0] exp2;
    int          fails_before;
    fails_before = checks_failed;
    apply_pads(1'b1);
    exp1 = expected_report(pad1, pad2, pad3, pad4, 1'b1, 1);
    exp2 = expected_report(pad1, pad2, pad3, pad4, 1'b1, 2);
    load_reports();
    shift_bits(2'b01, got1, got2);
    check_value("p1_only_stream", {8'h00, exp1}, got1);
    check_value("p2_untouched", {32{exp2[0]}}, got2);
    // port 2 still holds its report, no new strobe
    shift_bits(2'b10, got1, got2);
    check_value("p2_late_stream", {8'h00, exp2}, got2);
    check_value("p1_drained", 32'h0, got1);
    finish_test("single_port", fails_before);
  endtask

  task automatic sample_core_reset(input string name, input logic expected);
    @(negedge clk_ppu_21_47);
    check_value(name, {31'b0, expected}, {31'b0, core_reset});
    @(posedge clk_ppu_21_47);
  endtask

  task automatic sample_loader_reset(input string name, input logic expected);
    @(negedge clk_ppu_21_47);
    check_value(name, {31'b0, expected}, {31'b0, loader_reset});
    @(posedge clk_ppu_21_47);
  endtask

  task automatic run_download(input string name, input int cycles);
    int i;
    download <= 1'b1;
    @(posedge clk_ppu_21_47);
    for (i = 1; i < cycles; i++) begin
      sample_core_reset(name, 1'b1);
    end
    download <= 1'b0;
  endtask

  // counts cycles with core_reset high after download drops
  task automatic measure_release(input int busy_start, input int busy_len,
                                 output int high_cycles);
    logic released;
    high_cycles = 0;
    released = 1'b0;
    while (!released) begin
      @(negedge clk_ppu_21_47);
      if (!core_reset) begin
        released = 1'b1;
        // loader reset follows the zero count one cycle later
        check_value("loader_reset_at_release", 32'd0, {31'b0, loader_reset});
      end else begin
        high_cycles++;
        @(posedge clk_ppu_21_47);
        if (busy_len > 0 && high_cycles == busy_start) begin
          loader_busy <= 1'b1;
        end
        if (busy_len > 0 && high_cycles == busy_start + busy_len) begin
          loader_busy <= 1'b0;
        end
      end
    end
    @(posedge clk_ppu_21_47);
  endtask

  task automatic forced_reset_test();
    int fails_before;
    fails_before = checks_failed;
    sample_core_reset("running_before", 1'b0);
    loader_fail <= 1'b1;
    sample_core_reset("loader_fail_on", 1'b1);
    loader_fail <= 1'b0;
    sample_core_reset("loader_fail_off", 1'b0);
    external_reset <= 1'b1;
    sample_core_reset("external_reset_on", 1'b1);
    external_reset <= 1'b0;
    sample_core_reset("external_reset_off", 1'b0);
    finish_test("forced_reset", fails_before);
  endtask

  initial begin
    int high_cycles;
    int fails_before;
    void'($urandom(Seed));
    reset_nes <= 1'b1;
    pad1 <= '0;
    pad2 <= '0;
    pad3 <= '0;
    pad4 <= '0;
    multitap_enabled <= 1'b0;
    strobe <= 1'b0;
    port_clock <= '0;
    download <= 1'b0;
    loader_busy <= 1'b0;
    loader_fail <= 1'b0;
    external_reset <= 1'b0;
    repeat (10) @(posedge clk_ppu_21_47);
    reset_nes <= 1'b0;
    @(posedge clk_ppu_21_47);

    pad_read_test("no_tap", 1'b0, 20);
    pad_read_test("tap", 1'b1, 20);
    single_port_test();

    // no download seen so far, the core must still be held
    fails_before = checks_failed;
    repeat (10) sample_core_reset("hold_before_dl", 1'b1);
    sample_loader_reset("loader_reset_before_dl", 1'b1);
    run_download("hold_during_dl", 30);
    measure_release(0, 0, high_cycles);
    check_value("first_dl_release", 32'd255, high_cycles);
    sample_loader_reset("loader_reset_after_count", 1'b1);
    finish_test("first_download", fails_before);

    fails_before = checks_failed;
    run_download("hold_during_busy_dl", 30);
    measure_release(50, 100, high_cycles);
    check_value("busy_dl_release", 32'd355, high_cycles);
    finish_test("busy_pause", fails_before);

    forced_reset_test();

    $display("%0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, checks_failed);
    if (checks_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
nes_input_pkg.sv
pad_report_builder.sv
pad_shift_port.sv
core_reset_seq.sv
nes_input_top.sv
tb_nes_input.sv

// File: run.sh
#!/bin/sh
# build and run the NES input testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_nes_input -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_nes_input)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "All tests passed"; then
  exit 0
fi
echo "pass message not found"
exit 1
